/* hdl/dhcp_client_pkg.sv */
package dhcp_client_pkg;

  typedef logic [31:0] ipv4_t;
  typedef logic [31:0] xid_t;
  typedef logic [15:0] ipv4_id_t;

  typedef enum logic [7:0] {
    boot_request = 8'd1,
    boot_reply   = 8'd2
  } dhcp_op_e;

  typedef enum logic [7:0] {
    discover = 8'd1,
    offer    = 8'd2,
    request  = 8'd3,
    ack      = 8'd5
  } dhcp_msg_e;

  typedef enum logic [1:0] {
    expect_none,
    expect_offer,
    expect_ack
  } expect_e;

  typedef enum logic [2:0] {
    idle_s,
    discover_s,
    offer_s,
    request_s,
    ack_s
  } fsm_state_e;

  localparam int TIMEOUT_TICKS = 200; // cycles per attempt
  localparam int MAX_TRIES     = 3;

  localparam int TICK_W = $clog2(TIMEOUT_TICKS);
  localparam int TRY_W  = $clog2(MAX_TRIES);

  localparam xid_t XID_SEED = 32'h1d0c_a5e3;
  localparam xid_t XID_POLY = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1

  localparam ipv4_id_t IPV4_ID_INIT = 16'h4a10;

  localparam ipv4_t IPV4_BROADCAST = 32'hffff_ffff;

endpackage : dhcp_client_pkg

/* hdl/dhcp_lease_if.sv */
interface dhcp_lease_if;
  import dhcp_client_pkg::*;

  logic  offer_hit;
  logic  ack_hit;
  ipv4_t offered_ip;
  ipv4_t server_ip;
  ipv4_t assig_ip;
  ipv4_t router_ip;
  logic  router_val;
  ipv4_t subnet_mask;
  logic  subnet_mask_val;

  modport filter (
    output offer_hit, ack_hit, offered_ip, server_ip, assig_ip,
    output router_ip, router_val, subnet_mask, subnet_mask_val
  );

  modport fsm (input offer_hit, ack_hit);

  modport builder (input offered_ip, server_ip);

endinterface : dhcp_lease_if

/* hdl/dhcp_xid_lfsr.sv */
module dhcp_xid_lfsr (
  input  logic                  clk,
  input  logic                  rst,
  output dhcp_client_pkg::xid_t xid
);
  import dhcp_client_pkg::*;

  // galois form, shifts right
  always_ff @(posedge clk) begin
    if (rst) begin
      xid <= XID_SEED;
    end else if (xid[0]) begin
      xid <= {1'b0, xid[31:1]} ^ XID_POLY;
    end else begin
      xid <= {1'b0, xid[31:1]};
    end
  end

  // an all-zero state would lock up
  a_nonzero : assert property (@(posedge clk) disable iff (rst) xid != '0)
    else $error("xid lfsr reached zero");

endmodule : dhcp_xid_lfsr

/* hdl/dhcp_retry_timer.sv */
module dhcp_retry_timer (
  input  logic clk,
  input  logic rst,
  input  logic run,
  input  logic restart,
  input  logic clear_tries,
  output logic retry,
  output logic give_up
);
  import dhcp_client_pkg::*;

  logic [TICK_W-1:0] tick_cnt;
  logic [TRY_W-1:0]  tries;
  logic              expire;
  logic              last_try;

  assign expire   = run && !restart && (tick_cnt == TICK_W'(TIMEOUT_TICKS - 1));
  assign last_try = (tries == TRY_W'(MAX_TRIES - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      tick_cnt <= '0;
      tries    <= '0;
      retry    <= 1'b0;
      give_up  <= 1'b0;
    end else begin
      retry   <= expire && !last_try;
      give_up <= expire && last_try;

      if (restart || expire) begin
        tick_cnt <= '0; // wrap
      end else if (run) begin
        tick_cnt <= tick_cnt + 1'b1;
      end

      if (clear_tries) begin
        tries <= '0;
      end else if (expire && !last_try) begin
        tries <= tries + 1'b1;
      end
    end
  end

  // timer events are single pulses
  a_one_event : assert property (@(posedge clk) disable iff (rst)
    (retry || give_up) |=> !(retry || give_up))
    else $error("retry or give_up on consecutive cycles");

endmodule : dhcp_retry_timer

/* hdl/dhcp_rx_filter.sv */
module dhcp_rx_filter (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       rx_val,
  input  dhcp_client_pkg::dhcp_op_e  rx_op,
  input  dhcp_client_pkg::xid_t      rx_xid,
  input  dhcp_client_pkg::dhcp_msg_e rx_msg_type,
  input  dhcp_client_pkg::ipv4_t     rx_yiaddr,
  input  dhcp_client_pkg::ipv4_t     rx_siaddr,
  input  dhcp_client_pkg::ipv4_t     rx_router,
  input  logic                       rx_router_pres,
  input  dhcp_client_pkg::ipv4_t     rx_mask,
  input  logic                       rx_mask_pres,
  input  dhcp_client_pkg::xid_t      cur_xid,
  input  dhcp_client_pkg::expect_e   expect_type,
  dhcp_lease_if.filter               lease
);
  import dhcp_client_pkg::*;

  logic reply_ok;
  logic offer_acc;
  logic ack_acc;

  assign reply_ok  = rx_val && (rx_op == boot_reply) && (rx_xid == cur_xid);
  assign offer_acc = reply_ok && (expect_type == expect_offer) && (rx_msg_type == offer);
  assign ack_acc   = reply_ok && (expect_type == expect_ack) && (rx_msg_type == ack);

  always_ff @(posedge clk) begin
    if (rst) begin
      lease.offer_hit       <= 1'b0;
      lease.ack_hit         <= 1'b0;
      lease.router_val      <= 1'b0;
      lease.subnet_mask_val <= 1'b0;
    end else begin
      lease.offer_hit <= offer_acc;
      lease.ack_hit   <= ack_acc;
      // waiting for an offer starts a fresh exchange without old options
      if (expect_type == expect_offer) begin
        lease.router_val      <= 1'b0;
        lease.subnet_mask_val <= 1'b0;
      end else if (ack_acc) begin
        lease.router_val      <= rx_router_pres;
        lease.subnet_mask_val <= rx_mask_pres;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (offer_acc) begin
      lease.offered_ip <= rx_yiaddr;
      lease.server_ip  <= rx_siaddr;
    end
    if (ack_acc) begin
      lease.assig_ip <= rx_yiaddr;
      if (rx_router_pres) begin
        lease.router_ip <= rx_router;
      end
      if (rx_mask_pres) begin
        lease.subnet_mask <= rx_mask;
      end
    end
  end

  // an ack never lands on the cycle after its offer
  a_one_hit : assert property (@(posedge clk) disable iff (rst)
    lease.offer_hit |=> !lease.ack_hit)
    else $error("ack_hit right after offer_hit");

endmodule : dhcp_rx_filter

/* hdl/dhcp_tx_builder.sv */
module dhcp_tx_builder (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        send,
  input  dhcp_client_pkg::dhcp_msg_e  send_kind,
  input  logic                        new_xid,
  input  dhcp_client_pkg::xid_t       lfsr_xid,
  input  dhcp_client_pkg::ipv4_t      pref_ip,
  dhcp_lease_if.builder               lease,
  output logic                        tx_val,
  output dhcp_client_pkg::dhcp_op_e   tx_op,
  output dhcp_client_pkg::xid_t       tx_xid,
  output dhcp_client_pkg::dhcp_msg_e  tx_msg_type,
  output dhcp_client_pkg::ipv4_t      tx_req_ip,
  output dhcp_client_pkg::ipv4_t      tx_srv_id,
  output dhcp_client_pkg::ipv4_t      tx_dst_ip,
  output dhcp_client_pkg::ipv4_id_t   tx_ipv4_id
);
  import dhcp_client_pkg::*;

  always_ff @(posedge clk) begin
    if (rst) begin
      tx_val     <= 1'b0;
      tx_ipv4_id <= IPV4_ID_INIT;
    end else begin
      tx_val <= send;
      if (send) begin
        tx_ipv4_id <= tx_ipv4_id + 1'b1;
      end
    end
  end

  // tx_xid doubles as the current transaction id for the filter
  always_ff @(posedge clk) begin
    if (new_xid) begin
      tx_xid <= lfsr_xid;
    end
    if (send) begin
      tx_op       <= boot_request;
      tx_msg_type <= send_kind;
      tx_dst_ip   <= IPV4_BROADCAST; // no address yet, always broadcast
      if (send_kind == request) begin
        tx_req_ip <= lease.offered_ip;
        tx_srv_id <= lease.server_ip;
      end else begin
        tx_req_ip <= pref_ip;
        tx_srv_id <= '0;
      end
    end
  end

endmodule : dhcp_tx_builder

/* hdl/dhcp_client_fsm.sv */
module dhcp_client_fsm (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start,
  dhcp_lease_if.fsm                  lease,
  input  logic                       retry,
  input  logic                       give_up,
  output logic                       send,
  output dhcp_client_pkg::dhcp_msg_e send_kind,
  output logic                       new_xid,
  output dhcp_client_pkg::expect_e   expect_type,
  output logic                       timer_run,
  output logic                       timer_restart,
  output logic                       clear_tries,
  output logic                       success,
  output logic                       fail,
  output logic                       ready
);
  import dhcp_client_pkg::*;

  fsm_state_e state;
  logic       start_acc;
  logic       ack_now;
  logic       busy;

  assign busy      = (state != idle_s);
  assign start_acc = start && !busy; // ignored mid-exchange
  assign ack_now   = (state == ack_s) && lease.ack_hit;

  assign timer_run     = busy;
  assign timer_restart = (state == discover_s);
  assign clear_tries   = start_acc;

  always_comb begin
    case (state)
      offer_s: expect_type = expect_offer;
      ack_s:   expect_type = expect_ack;
      default: expect_type = expect_none;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= idle_s;
      send    <= 1'b0;
      new_xid <= 1'b0;
      success <= 1'b0;
      fail    <= 1'b0;
      ready   <= 1'b0;
    end else begin
      send    <= 1'b0;
      new_xid <= 1'b0;
      case (state)
        idle_s: begin
          if (start_acc) begin
            state     <= discover_s;
            send      <= 1'b1;
            send_kind <= discover;
            new_xid   <= 1'b1;
            success   <= 1'b0;
            fail      <= 1'b0;
            ready     <= 1'b0;
          end
        end
        discover_s: state <= offer_s;
        offer_s: begin
          if (lease.offer_hit) begin
            state     <= request_s;
            send      <= 1'b1;
            send_kind <= request;
          end
        end
        request_s: state <= ack_s;
        ack_s: begin
          if (lease.ack_hit) begin
            state   <= idle_s;
            success <= 1'b1;
            ready   <= 1'b1;
          end
        end
        default: state <= idle_s;
      endcase

      // timer events win over the normal sequence, a late ack still counts
      if (busy && !ack_now) begin
        if (give_up) begin
          state <= idle_s;
          send  <= 1'b0;
          fail  <= 1'b1;
          ready <= 1'b1;
        end else if (retry) begin
          state     <= discover_s;
          send      <= 1'b1;
          send_kind <= discover;
          new_xid   <= 1'b1;
        end
      end
    end
  end

  a_send_state : assert property (@(posedge clk) disable iff (rst)
    send |-> (state inside {discover_s, request_s}))
    else $error("send outside discover_s or request_s");

endmodule : dhcp_client_fsm

/* hdl/dhcp_client_top.sv */
module dhcp_client_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start,
  input  dhcp_client_pkg::ipv4_t     pref_ip,
  input  logic                       rx_val,
  input  dhcp_client_pkg::dhcp_op_e  rx_op,
  input  dhcp_client_pkg::xid_t      rx_xid,
  input  dhcp_client_pkg::dhcp_msg_e rx_msg_type,
  input  dhcp_client_pkg::ipv4_t     rx_yiaddr,
  input  dhcp_client_pkg::ipv4_t     rx_siaddr,
  input  dhcp_client_pkg::ipv4_t     rx_router,
  input  logic                       rx_router_pres,
  input  dhcp_client_pkg::ipv4_t     rx_mask,
  input  logic                       rx_mask_pres,
  output logic                       tx_val,
  output dhcp_client_pkg::dhcp_op_e  tx_op,
  output dhcp_client_pkg::xid_t      tx_xid,
  output dhcp_client_pkg::dhcp_msg_e tx_msg_type,
  output dhcp_client_pkg::ipv4_t     tx_req_ip,
  output dhcp_client_pkg::ipv4_t     tx_srv_id,
  output dhcp_client_pkg::ipv4_t     tx_dst_ip,
  output dhcp_client_pkg::ipv4_id_t  tx_ipv4_id,
  output logic                       success,
  output logic                       fail,
  output logic                       ready,
  output dhcp_client_pkg::ipv4_t     assig_ip,
  output dhcp_client_pkg::ipv4_t     router_ip,
  output logic                       router_val,
  output dhcp_client_pkg::ipv4_t     subnet_mask,
  output logic                       subnet_mask_val
);
  import dhcp_client_pkg::*;

  xid_t      lfsr_xid;
  logic      send;
  dhcp_msg_e send_kind;
  logic      new_xid;
  expect_e   expect_type;
  logic      timer_run;
  logic      timer_restart;
  logic      clear_tries;
  logic      retry;
  logic      give_up;

  dhcp_lease_if lease ();

  dhcp_xid_lfsr u_lfsr (
    .clk (clk),
    .rst (rst),
    .xid (lfsr_xid)
  );

  dhcp_retry_timer u_timer (
    .clk         (clk),
    .rst         (rst),
    .run         (timer_run),
    .restart     (timer_restart),
    .clear_tries (clear_tries),
    .retry       (retry),
    .give_up     (give_up)
  );

  dhcp_rx_filter u_filter (
    .clk            (clk),
    .rst            (rst),
    .rx_val         (rx_val),
    .rx_op          (rx_op),
    .rx_xid         (rx_xid),
    .rx_msg_type    (rx_msg_type),
    .rx_yiaddr      (rx_yiaddr),
    .rx_siaddr      (rx_siaddr),
    .rx_router      (rx_router),
    .rx_router_pres (rx_router_pres),
    .rx_mask        (rx_mask),
    .rx_mask_pres   (rx_mask_pres),
    .cur_xid        (tx_xid), // builder holds the live xid
    .expect_type    (expect_type),
    .lease          (lease.filter)
  );

  dhcp_tx_builder u_builder (
    .clk         (clk),
    .rst         (rst),
    .send        (send),
    .send_kind   (send_kind),
    .new_xid     (new_xid),
    .lfsr_xid    (lfsr_xid),
    .pref_ip     (pref_ip),
    .lease       (lease.builder),
    .tx_val      (tx_val),
    .tx_op       (tx_op),
    .tx_xid      (tx_xid),
    .tx_msg_type (tx_msg_type),
    .tx_req_ip   (tx_req_ip),
    .tx_srv_id   (tx_srv_id),
    .tx_dst_ip   (tx_dst_ip),
    .tx_ipv4_id  (tx_ipv4_id)
  );

  dhcp_client_fsm u_fsm (
    .clk           (clk),
    .rst           (rst),
    .start         (start),
    .lease         (lease.fsm),
    .retry         (retry),
    .give_up       (give_up),
    .send          (send),
    .send_kind     (send_kind),
    .new_xid       (new_xid),
    .expect_type   (expect_type),
    .timer_run     (timer_run),
    .timer_restart (timer_restart),
    .clear_tries   (clear_tries),
    .success       (success),
    .fail          (fail),
    .ready         (ready)
  );

  assign assig_ip        = lease.assig_ip;
  assign router_ip       = lease.router_ip;
  assign router_val      = lease.router_val;
  assign subnet_mask     = lease.subnet_mask;
  assign subnet_mask_val = lease.subnet_mask_val;

endmodule : dhcp_client_top

/* testbench/tb_dhcp_client_top.sv */
module tb_dhcp_client_top;
  timeunit 1ns;
  timeprecision 100ps;
  import dhcp_client_pkg::*;

  typedef struct packed {
    logic [3:0] mode;
    ipv4_t      pref;
    ipv4_t      offered;
    ipv4_t      server;
    ipv4_t      router;
    logic       router_pres;
    ipv4_t      mask;
    logic       mask_pres;
    logic       exp_ok;
    logic [3:0] exp_disc;
  } scen_t;

  logic      clk;
  logic      rst;
  logic      start;
  ipv4_t     pref_ip;
  logic      rx_val;
  dhcp_op_e  rx_op;
  xid_t      rx_xid;
  dhcp_msg_e rx_msg_type;
  ipv4_t     rx_yiaddr, rx_siaddr, rx_router, rx_mask;
  logic      rx_router_pres, rx_mask_pres;
  logic      tx_val;
  dhcp_op_e  tx_op;
  xid_t      tx_xid;
  dhcp_msg_e tx_msg_type;
  ipv4_t     tx_req_ip, tx_srv_id, tx_dst_ip;
  ipv4_id_t  tx_ipv4_id;
  logic      success, fail, ready;
  ipv4_t     assig_ip, router_ip, subnet_mask;
  logic      router_val, subnet_mask_val;

  scen_t     scen_q[$];
  scen_t     cur;
  int        seed = 79095;
  int        n_checks = 0;
  int        n_errors = 0;
  int        cycles = 0;
  int        cycle_limit = 1000000;
  int        n_disc;
  xid_t      disc_xid;
  ipv4_id_t  exp_id;

  dhcp_client_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the DUT never finished", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    assert (got === exp) else begin
      n_errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // no message may leave while the server is busy
  task automatic quiet_cycle();
    @(posedge clk);
    check_eq("unexpected tx_val", 32'(tx_val), 32'd0);
  endtask

  task automatic server_delay();
    int d;
    d = $random(seed);
    d = 2 + (d & 32'h7fff_ffff) % 19;
    repeat (d) quiet_cycle();
  endtask

  task automatic send_reply(input dhcp_msg_e kind, input xid_t xid);
    quiet_cycle();
    rx_val         <= 1'b1;
    rx_op          <= boot_reply;
    rx_xid         <= xid;
    rx_msg_type    <= kind;
    rx_yiaddr      <= cur.offered;
    rx_siaddr      <= cur.server;
    rx_router      <= cur.router;
    rx_router_pres <= cur.router_pres;
    rx_mask        <= cur.mask;
    rx_mask_pres   <= cur.mask_pres;
    quiet_cycle();
    rx_val <= 1'b0;
  endtask

  task automatic serve_message();
    check_eq("tx_op", 32'(tx_op), 32'(boot_request));
    check_eq("tx_dst_ip", tx_dst_ip, IPV4_BROADCAST);
    exp_id = exp_id + 16'd1;
    check_eq("tx_ipv4_id", 32'(tx_ipv4_id), 32'(exp_id));
    if (tx_msg_type == discover) begin
      n_disc++;
      check_eq("discover tx_req_ip", tx_req_ip, cur.pref);
      check_eq("discover tx_srv_id", tx_srv_id, 32'd0);
      if (n_disc > 1) begin
        n_checks++;
        assert (tx_xid !== disc_xid) else begin
          n_errors++;
          $display("mismatch at %0t: retry reused xid %h", $time, tx_xid);
        end
      end
      disc_xid = tx_xid;
      server_delay();
      check_eq("router_val after start", 32'(router_val), 32'd0);
      check_eq("subnet_mask_val after start", 32'(subnet_mask_val), 32'd0);
      if (cur.mode == 4'd2 && n_disc == 1) begin
        send_reply(ack, disc_xid); // ack while an offer is due
        server_delay();
        send_reply(offer, disc_xid ^ 32'h0000_0100);
        server_delay();
      end
      if (!(cur.mode == 4'd1 && n_disc == 1) && cur.mode != 4'd4) begin
        send_reply(offer, disc_xid);
      end
    end else if (tx_msg_type == request) begin
      check_eq("request tx_xid", tx_xid, disc_xid);
      check_eq("request tx_req_ip", tx_req_ip, cur.offered);
      check_eq("request tx_srv_id", tx_srv_id, cur.server);
      server_delay();
      if (cur.mode != 4'd3) begin
        send_reply(ack, disc_xid);
      end
    end else begin
      check_eq("tx_msg_type", 32'(tx_msg_type), 32'(discover));
    end
  endtask

  task automatic run_scenario();
    bit done;
    done     = 1'b0;
    n_disc   = 0;
    disc_xid = '0;
    @(posedge clk);
    pref_ip <= cur.pref;
    start   <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    while (!done) begin
      @(posedge clk);
      if (tx_val) begin
        serve_message();
      end else if (ready) begin
        done = 1'b1;
      end
    end
    check_eq("discover count", 32'(n_disc), 32'(cur.exp_disc));
    check_eq("success", 32'(success), 32'(cur.exp_ok));
    check_eq("fail", 32'(fail), 32'(!cur.exp_ok));
    check_eq("router_val", 32'(router_val), 32'(cur.exp_ok && cur.router_pres));
    check_eq("subnet_mask_val", 32'(subnet_mask_val), 32'(cur.exp_ok && cur.mask_pres));
    if (cur.exp_ok) begin
      check_eq("assig_ip", assig_ip, cur.offered);
      if (cur.router_pres) begin
        check_eq("router_ip", router_ip, cur.router);
      end
      if (cur.mask_pres) begin
        check_eq("subnet_mask", subnet_mask, cur.mask);
      end
    end
  endtask

  task automatic load_stim();
    int          fd;
    int          n;
    string       line;
    logic [31:0] fld [10];
    scen_t       s;
    fd = $fopen("testbench/dhcp_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open testbench/dhcp_stim.txt");
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", fld[0], fld[1], fld[2],
                    fld[3], fld[4], fld[5], fld[6], fld[7], fld[8], fld[9]);
        if (n == 10) begin
          s.mode        = fld[0][3:0];
          s.pref        = fld[1];
          s.offered     = fld[2];
          s.server      = fld[3];
          s.router      = fld[4];
          s.router_pres = fld[5][0];
          s.mask        = fld[6];
          s.mask_pres   = fld[7][0];
          s.exp_ok      = fld[8][0];
          s.exp_disc    = fld[9][3:0];
          scen_q.push_back(s);
        end
      end
    end
    $fclose(fd);
  endtask

  initial begin
    rst            <= 1'b1;
    start          <= 1'b0;
    pref_ip        <= '0;
    rx_val         <= 1'b0;
    rx_op          <= boot_reply;
    rx_xid         <= '0;
    rx_msg_type    <= offer;
    rx_yiaddr      <= '0;
    rx_siaddr      <= '0;
    rx_router      <= '0;
    rx_router_pres <= 1'b0;
    rx_mask        <= '0;
    rx_mask_pres   <= 1'b0;
    load_stim();
    if (scen_q.size() == 0) begin
      n_errors++;
      $display("no scenarios were read from the stimulus file");
    end
    cycle_limit = scen_q.size() * (MAX_TRIES + 1) * TIMEOUT_TICKS + 500;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_eq("tx_val after reset", 32'(tx_val), 32'd0);
    check_eq("ready after reset", 32'(ready), 32'd0);
    check_eq("success after reset", 32'(success), 32'd0);
    check_eq("fail after reset", 32'(fail), 32'd0);
    check_eq("router_val after reset", 32'(router_val), 32'd0);
    check_eq("subnet_mask_val after reset", 32'(subnet_mask_val), 32'd0);
    check_eq("tx_ipv4_id after reset", 32'(tx_ipv4_id), 32'(IPV4_ID_INIT));
    exp_id = IPV4_ID_INIT;
    foreach (scen_q[i]) begin
      cur = scen_q[i];
      run_scenario();
    end
    $display("scenarios %0d, checks %0d, errors %0d", scen_q.size(), n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule : tb_dhcp_client_top

/* testbench/dhcp_stim.txt */
# mode pref_ip offered server router router_pres mask mask_pres exp_success exp_discovers
# mode 0 normal, 1 first offer lost, 2 stray ack and wrong xid offer first, 3 acks lost, 4 no replies
0 c0a80164 c0a80164 c0a80101 c0a80101 1 ffffff00 1 1 1
0 0a000005 0a00002a 0a000001 0a0000fe 1 ff000000 0 1 1
0 00000000 ac100a07 ac100001 ac100001 0 ffff0000 1 1 1
2 c0a80132 c0a80133 c0a80102 c0a80102 1 ffffff00 1 1 1
1 0a0a0a0a 0a0a0a0b 0a0a0a01 0a0a0a01 0 fffffc00 1 1 2
3 c0a80164 c0a80165 c0a80101 c0a80101 1 ffffff00 1 0 3
4 c0a80164 c0a80165 c0a80101 c0a80101 0 00000000 0 0 3
0 c0a80010 c0a80011 c0a80001 c0a80001 1 ffffff80 1 1 1

/* dhcp_client_top.f */
hdl/dhcp_client_pkg.sv
hdl/dhcp_lease_if.sv
hdl/dhcp_xid_lfsr.sv
hdl/dhcp_retry_timer.sv
hdl/dhcp_rx_filter.sv
hdl/dhcp_tx_builder.sv
hdl/dhcp_client_fsm.sv
hdl/dhcp_client_top.sv
testbench/tb_dhcp_client_top.sv

/* Makefile */
VERILATOR ?= verilator
TB_TOP    ?= tb_dhcp_client_top
RTL_TOP   ?= dhcp_client_top
FILELIST  ?= dhcp_client_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing --timescale $(TIMESCALE) \
		-f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) -f $(FILELIST) \
		--top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation reported errors"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
